/* include/rv_isa_defs.svh */
`ifndef RV_ISA_DEFS_SVH
`define RV_ISA_DEFS_SVH

////////////////////////////////////////////////////////////
// major opcodes of the kept subset
////////////////////////////////////////////////////////////

localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;

////////////////////////////////////////////////////////////
// funct3 of the integer ALU group
////////////////////////////////////////////////////////////

// add and sub share one code, funct7 tells them apart
localparam logic [2:0] F3_ADD_SUB = 3'b000;
localparam logic [2:0] F3_SLL     = 3'b001;
localparam logic [2:0] F3_SLT     = 3'b010;
localparam logic [2:0] F3_SLTU    = 3'b011;
localparam logic [2:0] F3_XOR     = 3'b100;
// logical and arithmetic right shift
localparam logic [2:0] F3_SRL_SRA = 3'b101;
localparam logic [2:0] F3_OR      = 3'b110;
localparam logic [2:0] F3_AND     = 3'b111;

////////////////////////////////////////////////////////////
// funct7
////////////////////////////////////////////////////////////

// selects sub and sra
localparam logic [6:0] F7_ALT = 7'b0100000;

`endif

/* hw/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  ////////////////////////////////////////////////////////////
  // datapath sizes
  ////////////////////////////////////////////////////////////

  // data and address width
  localparam int XLEN = 32;

  // register index width, 32 architectural registers
  localparam int REG_BITS = 5;

  ////////////////////////////////////////////////////////////
  // program counter
  ////////////////////////////////////////////////////////////

  // first fetch after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // instructions are one word apart
  localparam logic [XLEN-1:0] PC_STEP = 32'd4;

endpackage

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

  `include "rv_isa_defs.svh"

  // one instruction word, four field layouts
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } rv_b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_fmt_t;

  typedef union packed {
    rv_r_fmt_t r;
    rv_i_fmt_t i;
    rv_b_fmt_t b;
    rv_u_fmt_t u;
  } rv_instr_u;

  localparam int ALU_OP_BITS = 4;

  localparam logic [ALU_OP_BITS-1:0] ALU_ADD    = 4'd0;
  localparam logic [ALU_OP_BITS-1:0] ALU_SUB    = 4'd1;
  localparam logic [ALU_OP_BITS-1:0] ALU_AND    = 4'd2;
  localparam logic [ALU_OP_BITS-1:0] ALU_OR     = 4'd3;
  localparam logic [ALU_OP_BITS-1:0] ALU_XOR    = 4'd4;
  localparam logic [ALU_OP_BITS-1:0] ALU_SLL    = 4'd5;
  localparam logic [ALU_OP_BITS-1:0] ALU_SRL    = 4'd6;
  localparam logic [ALU_OP_BITS-1:0] ALU_SRA    = 4'd7;
  localparam logic [ALU_OP_BITS-1:0] ALU_SLT    = 4'd8;
  localparam logic [ALU_OP_BITS-1:0] ALU_SLTU   = 4'd9;
  // lui passes the immediate straight through
  localparam logic [ALU_OP_BITS-1:0] ALU_PASS_B = 4'd10;

  // branch conditions, same encoding as branch funct3
  localparam logic [2:0] BR_EQ  = 3'b000;
  localparam logic [2:0] BR_NE  = 3'b001;
  localparam logic [2:0] BR_LT  = 3'b100;
  localparam logic [2:0] BR_GE  = 3'b101;
  localparam logic [2:0] BR_LTU = 3'b110;
  localparam logic [2:0] BR_GEU = 3'b111;

endpackage

/* hw/rv_pipe_if.sv */
`timescale 1ns/1ps

interface rv_pipe_if;
  import rv_pipe_pkg::*;
  import rv_isa_pkg::*;

  // execute holds an instruction this cycle
  logic                   valid;
  logic [XLEN-1:0]        pc;

  // source indices travel along for forwarding
  logic [REG_BITS-1:0]    rs1_addr;
  logic [REG_BITS-1:0]    rs2_addr;
  logic [XLEN-1:0]        rs1_data;
  logic [XLEN-1:0]        rs2_data;

  // zero for branches and unknown opcodes
  logic [REG_BITS-1:0]    rd_addr;

  logic                   use_imm;
  logic [XLEN-1:0]        imm;
  logic [ALU_OP_BITS-1:0] alu_op;
  logic                   is_branch;
  logic [2:0]             br_cond;

  modport dec (
    output valid, pc, rs1_addr, rs2_addr, rs1_data, rs2_data, rd_addr,
    output use_imm, imm, alu_op, is_branch, br_cond
  );

  modport exe (
    input valid, pc, rs1_addr, rs2_addr, rs1_data, rs2_data, rd_addr,
    input use_imm, imm, alu_op, is_branch, br_cond
  );

endinterface

/* hw/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [rv_pipe_pkg::XLEN-1:0] instr_i,
  input  logic                        redirect_i,
  input  logic [rv_pipe_pkg::XLEN-1:0] redirect_pc_i,
  output logic [rv_pipe_pkg::XLEN-1:0] instr_addr_o,
  output logic                        fetch_valid_o,
  output logic [rv_pipe_pkg::XLEN-1:0] fetch_pc_o,
  output logic [rv_pipe_pkg::XLEN-1:0] fetch_word_o
);
  import rv_pipe_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic            fetch_valid_q;
  logic [XLEN-1:0] fetch_pc_q;
  logic [XLEN-1:0] fetch_word_q;

  // instruction memory answers in the same cycle
  assign instr_addr_o = pc_q;

  ////////////////////////////////////////////////////////////
  // program counter and valid flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q          <= RESET_PC;
      fetch_valid_q <= 1'b0;
    end else if (redirect_i) begin
      // word on the port is on the wrong path
      pc_q          <= redirect_pc_i;
      fetch_valid_q <= 1'b0;
    end else begin
      pc_q          <= pc_q + PC_STEP;
      fetch_valid_q <= 1'b1;
    end
  end

  // fetched word and its address
  always_ff @(posedge clk_i) begin
    fetch_pc_q   <= pc_q;
    fetch_word_q <= instr_i;
  end

  assign fetch_valid_o = fetch_valid_q;
  assign fetch_pc_o    = fetch_pc_q;
  assign fetch_word_o  = fetch_word_q;

endmodule

/* hw/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            fetch_valid_i,
  input  logic [rv_pipe_pkg::XLEN-1:0]     fetch_pc_i,
  input  logic [rv_pipe_pkg::XLEN-1:0]     fetch_word_i,
  input  logic                            flush_i,
  input  logic [rv_pipe_pkg::XLEN-1:0]     rs1_data_i,
  input  logic [rv_pipe_pkg::XLEN-1:0]     rs2_data_i,
  output logic [rv_pipe_pkg::REG_BITS-1:0] rs1_addr_o,
  output logic [rv_pipe_pkg::REG_BITS-1:0] rs2_addr_o,
  rv_pipe_if.dec                          pipe
);
  import rv_pipe_pkg::*;
  import rv_isa_pkg::*;

  rv_instr_u              instr;
  logic [REG_BITS-1:0]    dec_rd;
  logic [XLEN-1:0]        dec_imm;
  logic                   dec_use_imm;
  logic [ALU_OP_BITS-1:0] dec_alu_op;
  logic                   dec_branch;

  // alu group, sub only exists in register form
  function automatic logic [ALU_OP_BITS-1:0] alu_sel(
    input logic [2:0] f3,
    input logic       sub_sel,
    input logic       sra_sel
  );
    case (f3)
      F3_ADD_SUB: return sub_sel ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return sra_sel ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      F3_AND:     return ALU_AND;
      default:    return ALU_ADD;
    endcase
  endfunction

  assign instr      = fetch_word_i;
  assign rs1_addr_o = instr.r.rs1;
  assign rs2_addr_o = instr.r.rs2;

  ////////////////////////////////////////////////////////////
  // field decode and immediate formation
  ////////////////////////////////////////////////////////////

  always_comb begin
    dec_rd      = '0;
    dec_imm     = '0;
    dec_use_imm = 1'b0;
    dec_alu_op  = ALU_ADD;
    dec_branch  = 1'b0;
    case (instr.r.opcode)
      OPC_OP: begin
        dec_rd     = instr.r.rd;
        dec_alu_op = alu_sel(instr.r.funct3, instr.r.funct7 == F7_ALT,
                             instr.r.funct7 == F7_ALT);
      end
      OPC_OP_IMM: begin
        dec_rd      = instr.i.rd;
        dec_imm     = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};
        dec_use_imm = 1'b1;
        // shift immediates carry funct7 in the upper bits
        dec_alu_op  = alu_sel(instr.i.funct3, 1'b0, instr.r.funct7 == F7_ALT);
      end
      OPC_LUI: begin
        dec_rd      = instr.u.rd;
        dec_imm     = {instr.u.imm, 12'b0};
        dec_use_imm = 1'b1;
        dec_alu_op  = ALU_PASS_B;
      end
      OPC_BRANCH: begin
        dec_imm    = {{(XLEN-12){instr.b.imm12}}, instr.b.imm11,
                      instr.b.imm10_5, instr.b.imm4_1, 1'b0};
        dec_branch = 1'b1;
      end
      // unknown opcodes fall through as a no-op
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // decode register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      pipe.valid <= 1'b0;
    end else begin
      pipe.valid <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    pipe.pc        <= fetch_pc_i;
    pipe.rs1_addr  <= instr.r.rs1;
    pipe.rs2_addr  <= instr.r.rs2;
    pipe.rs1_data  <= rs1_data_i;
    pipe.rs2_data  <= rs2_data_i;
    pipe.rd_addr   <= dec_rd;
    pipe.use_imm   <= dec_use_imm;
    pipe.imm       <= dec_imm;
    pipe.alu_op    <= dec_alu_op;
    pipe.is_branch <= dec_branch;
    pipe.br_cond   <= instr.b.funct3;
  end

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic                            clk_i,
  input  logic [rv_pipe_pkg::REG_BITS-1:0] rs1_addr_i,
  input  logic [rv_pipe_pkg::REG_BITS-1:0] rs2_addr_i,
  input  logic                            wr_en_i,
  input  logic [rv_pipe_pkg::REG_BITS-1:0] wr_addr_i,
  input  logic [rv_pipe_pkg::XLEN-1:0]     wr_data_i,
  output logic [rv_pipe_pkg::XLEN-1:0]     rs1_data_o,
  output logic [rv_pipe_pkg::XLEN-1:0]     rs2_data_o
);
  import rv_pipe_pkg::*;

  // x1..x31, x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  logic            rs1_hit;
  logic            rs2_hit;

  always_ff @(posedge clk_i) begin
    if (wr_en_i && (wr_addr_i != '0)) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  // same-cycle write wins over the stored value
  assign rs1_hit = wr_en_i && (wr_addr_i == rs1_addr_i);
  assign rs2_hit = wr_en_i && (wr_addr_i == rs2_addr_i);

  always_comb begin
    if (rs1_addr_i == '0) begin
      rs1_data_o = '0;
    end else if (rs1_hit) begin
      rs1_data_o = wr_data_i;
    end else begin
      rs1_data_o = regs_q[rs1_addr_i];
    end
  end

  always_comb begin
    if (rs2_addr_i == '0) begin
      rs2_data_o = '0;
    end else if (rs2_hit) begin
      rs2_data_o = wr_data_i;
    end else begin
      rs2_data_o = regs_q[rs2_addr_i];
    end
  end

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
  input  logic                            clk_i,
  input  logic                            reset_i,
  rv_pipe_if.exe                          pipe,
  output logic                            redirect_o,
  output logic [rv_pipe_pkg::XLEN-1:0]     redirect_pc_o,
  output logic                            wr_en_o,
  output logic [rv_pipe_pkg::REG_BITS-1:0] wr_addr_o,
  output logic [rv_pipe_pkg::XLEN-1:0]     wr_data_o,
  output logic                            retire_valid_o,
  output logic [rv_pipe_pkg::XLEN-1:0]     retire_pc_o,
  output logic [rv_pipe_pkg::REG_BITS-1:0] retire_rd_o,
  output logic [rv_pipe_pkg::XLEN-1:0]     retire_data_o
);
  import rv_pipe_pkg::*;
  import rv_isa_pkg::*;

  logic [XLEN-1:0]     op_a;
  logic [XLEN-1:0]     fwd_b;
  logic [XLEN-1:0]     op_b;
  logic [4:0]          shamt;
  logic [XLEN-1:0]     alu_res;
  logic                cmp_eq;
  logic                cmp_lt;
  logic                cmp_ltu;
  logic                br_taken;

  logic                wb_valid_q;
  logic                wb_wr_en_q;
  logic [XLEN-1:0]     wb_pc_q;
  logic [REG_BITS-1:0] wb_rd_q;
  logic [XLEN-1:0]     wb_data_q;

  ////////////////////////////////////////////////////////////
  // forwarding from the writeback register
  ////////////////////////////////////////////////////////////

  // write enable already implies a nonzero rd
  assign op_a  = (wb_wr_en_q && (wb_rd_q == pipe.rs1_addr)) ? wb_data_q : pipe.rs1_data;
  assign fwd_b = (wb_wr_en_q && (wb_rd_q == pipe.rs2_addr)) ? wb_data_q : pipe.rs2_data;
  assign op_b  = pipe.use_imm ? pipe.imm : fwd_b;
  assign shamt = op_b[4:0];

  always_comb begin
    case (pipe.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SLL:    alu_res = op_a << shamt;
      ALU_SRL:    alu_res = op_a >> shamt;
      ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // branch resolution
  ////////////////////////////////////////////////////////////

  // branches compare the two register operands
  assign cmp_eq  = (op_a == fwd_b);
  assign cmp_lt  = ($signed(op_a) < $signed(fwd_b));
  assign cmp_ltu = (op_a < fwd_b);

  always_comb begin
    case (pipe.br_cond)
      BR_EQ:   br_taken = cmp_eq;
      BR_NE:   br_taken = !cmp_eq;
      BR_LT:   br_taken = cmp_lt;
      BR_GE:   br_taken = !cmp_lt;
      BR_LTU:  br_taken = cmp_ltu;
      BR_GEU:  br_taken = !cmp_ltu;
      default: br_taken = 1'b0;
    endcase
  end

  // single-cycle pulse, the flush empties this stage next cycle
  assign redirect_o    = pipe.valid && pipe.is_branch && br_taken;
  assign redirect_pc_o = pipe.pc + pipe.imm;

  ////////////////////////////////////////////////////////////
  // writeback register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_q <= 1'b0;
      wb_wr_en_q <= 1'b0;
    end else begin
      wb_valid_q <= pipe.valid;
      wb_wr_en_q <= pipe.valid && (pipe.rd_addr != '0);
    end
  end

  // nothing written means nothing reported
  always_ff @(posedge clk_i) begin
    wb_pc_q   <= pipe.pc;
    wb_rd_q   <= pipe.rd_addr;
    wb_data_q <= (pipe.rd_addr == '0) ? '0 : alu_res;
  end

  assign wr_en_o        = wb_wr_en_q;
  assign wr_addr_o      = wb_rd_q;
  assign wr_data_o      = wb_data_q;
  assign retire_valid_o = wb_valid_q;
  assign retire_pc_o    = wb_pc_q;
  assign retire_rd_o    = wb_rd_q;
  assign retire_data_o  = wb_data_q;

endmodule

/* hw/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
  input  logic                            clk_i,
  input  logic                            reset_i,
  output logic [rv_pipe_pkg::XLEN-1:0]     instr_addr_o,
  input  logic [rv_pipe_pkg::XLEN-1:0]     instr_i,
  output logic                            retire_valid_o,
  output logic [rv_pipe_pkg::XLEN-1:0]     retire_pc_o,
  output logic [rv_pipe_pkg::REG_BITS-1:0] retire_rd_o,
  output logic [rv_pipe_pkg::XLEN-1:0]     retire_data_o
);
  import rv_pipe_pkg::*;

  logic                redirect;
  logic [XLEN-1:0]     redirect_pc;
  logic                fetch_valid;
  logic [XLEN-1:0]     fetch_pc;
  logic [XLEN-1:0]     fetch_word;
  logic [REG_BITS-1:0] rs1_addr;
  logic [REG_BITS-1:0] rs2_addr;
  logic [XLEN-1:0]     rs1_data;
  logic [XLEN-1:0]     rs2_data;
  logic                wr_en;
  logic [REG_BITS-1:0] wr_addr;
  logic [XLEN-1:0]     wr_data;

  // decode to execute
  rv_pipe_if u_pipe ();

  rv_fetch u_fetch (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_i       (instr_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .instr_addr_o  (instr_addr_o),
    .fetch_valid_o (fetch_valid),
    .fetch_pc_o    (fetch_pc),
    .fetch_word_o  (fetch_word)
  );

  rv_decode u_decode (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_valid_i (fetch_valid),
    .fetch_pc_i    (fetch_pc),
    .fetch_word_i  (fetch_word),
    .flush_i       (redirect),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .pipe          (u_pipe.dec)
  );

  rv_regfile u_regfile (
    .clk_i      (clk_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv_execute u_execute (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .pipe           (u_pipe.exe),
    .redirect_o     (redirect),
    .redirect_pc_o  (redirect_pc),
    .wr_en_o        (wr_en),
    .wr_addr_o      (wr_addr),
    .wr_data_o      (wr_data),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

endmodule

/* dv/rv_core_sva.sv */
`timescale 1ns/1ps

module rv_core_sva (
  input logic                            clk_i,
  input logic                            reset_i,
  input logic [rv_pipe_pkg::XLEN-1:0]     instr_addr_o,
  input logic [rv_pipe_pkg::XLEN-1:0]     instr_i,
  input logic                            retire_valid_o,
  input logic [rv_pipe_pkg::XLEN-1:0]     retire_pc_o,
  input logic [rv_pipe_pkg::REG_BITS-1:0] retire_rd_o
);
  import rv_pipe_pkg::*;
  import rv_isa_pkg::*;

  // words seen on the instruction port, indexed by word address
  logic [XLEN-1:0] seen_q [0:255];
  logic            retired_branch;

  always_ff @(posedge clk_i) begin
    seen_q[instr_addr_o[9:2]] <= instr_i;
  end

  assign retired_branch = (seen_q[retire_pc_o[9:2]][6:0] == OPC_BRANCH);

  // pipeline depth after reset
  a_no_early_retire: assert property (@(posedge clk_i)
    $fell(reset_i) |-> !retire_valid_o [*3])
    else $error("retirement within three cycles of reset release");

  a_addr_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    (instr_addr_o % PC_STEP) == 0)
    else $error("instruction address not word aligned");

  a_branch_no_rd: assert property (@(posedge clk_i) disable iff (reset_i)
    (retire_valid_o && retired_branch) |-> (retire_rd_o == '0))
    else $error("retired branch reports a destination register");

endmodule

bind rv_core_top rv_core_sva u_sva (.*);

/* dv/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;
  import rv_pipe_pkg::*;
  import rv_isa_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int MEM_WORDS    = 256;
  localparam int PROG_WORDS   = 64;
  // retire indices where the test groups end
  localparam int ALU_END      = 21;
  localparam int X0_END       = 23;
  localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

  logic                clk_i;
  logic                reset_i;
  logic [XLEN-1:0]     instr_addr_o;
  logic [XLEN-1:0]     instr_i;
  logic                retire_valid_o;
  logic [XLEN-1:0]     retire_pc_o;
  logic [REG_BITS-1:0] retire_rd_o;
  logic [XLEN-1:0]     retire_data_o;

  logic [XLEN-1:0] golden_mem [0:MEM_WORDS-1];
  logic [XLEN-1:0] prog_mem [0:PROG_WORDS-1];
  int prog_count;
  int exp_count;
  int ret_idx;
  int errors;
  int group_start_err;
  int cycles;
  int cycle_limit;
  int since_reset;
  bit done;

  rv_core_top u_dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_addr_o   (instr_addr_o),
    .instr_i        (instr_i),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  function automatic logic [XLEN-1:0] prog_word(input logic [XLEN-1:0] addr);
    int idx;
    if (^addr === 1'bx) return NOP_WORD;
    idx = addr / PC_STEP;
    if (idx >= prog_count || idx >= PROG_WORDS) return NOP_WORD;
    return prog_mem[idx];
  endfunction

  // short disassembly hint for error lines
  function automatic string instr_hint(input logic [XLEN-1:0] pc);
    rv_instr_u w;
    w = prog_word(pc);
    return $sformatf("opcode %07b f3 %03b rd x%0d rs1 x%0d rs2 x%0d",
                     w.r.opcode, w.r.funct3, w.r.rd, w.r.rs1, w.r.rs2);
  endfunction

  assign instr_i = prog_word(instr_addr_o);

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_pc(input int idx, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: retire %0d pc 0x%08h, expected 0x%08h", $time, idx, got, exp);
    end
  endtask

  task automatic check_rd(input int idx, input logic [REG_BITS-1:0] got,
                          input logic [REG_BITS-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: retire %0d rd x%0d, expected x%0d", $time, idx, got, exp);
    end
  endtask

  task automatic check_data(input int idx, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp, input logic [XLEN-1:0] pc);
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: retire %0d data 0x%08h, expected 0x%08h (%s)",
               $time, idx, got, exp, instr_hint(pc));
    end
  endtask

  task automatic report_group(input string name, input int count);
    $display("test %s: %0d retirements, %0d mismatches", name, count,
             errors - group_start_err);
    group_start_err = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // clock, reset and cycle limit
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
  end

  initial begin
    reset_i         = 1'b1;
    cycles          = 0;
    errors          = 0;
    group_start_err = 0;
    ret_idx         = 0;
    since_reset     = 0;
    done            = 1'b0;
    void'($urandom(98310));
    $readmemh("dv/rv_core_golden.txt", golden_mem);
    prog_count = golden_mem[0];
    exp_count  = golden_mem[1];
    if (prog_count <= 0 || prog_count > PROG_WORDS || exp_count <= 0) begin
      $display("golden file could not be read or holds no program");
      errors++;
      exp_count  = 0;
      prog_count = 0;
    end
    for (int i = 0; i < prog_count; i++) begin
      prog_mem[i] = golden_mem[2 + i];
    end
    cycle_limit = 3 * exp_count + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    while (!done && exp_count > 0 && cycles < cycle_limit) begin
      @(posedge clk_i);
    end
    if (!done && exp_count > 0) begin
      $display("run timed out after %0d cycles with %0d of %0d retirements seen",
               cycles, ret_idx, exp_count);
    end
    $display("%0d of %0d retirements checked, %0d errors", ret_idx, exp_count, errors);
    if (done && errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // retire monitor, sampled away from the active edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!reset_i && !done) begin
      since_reset++;
      if (retire_valid_o) begin
        int base;
        base = 2 + prog_count + 3 * ret_idx;
        if (ret_idx == 0) begin
          if (since_reset < 4) begin
            errors++;
            $display("first retirement came %0d cycles after reset, too early",
                     since_reset);
          end
          check_pc(0, retire_pc_o, RESET_PC);
          report_group("reset", 1);
        end
        check_pc(ret_idx, retire_pc_o, golden_mem[base]);
        check_rd(ret_idx, retire_rd_o, golden_mem[base + 1][REG_BITS-1:0]);
        check_data(ret_idx, retire_data_o, golden_mem[base + 2], retire_pc_o);
        ret_idx++;
        if (ret_idx == ALU_END) report_group("alu and forwarding", ALU_END);
        if (ret_idx == X0_END) report_group("x0", X0_END - ALU_END);
        if (ret_idx == exp_count) begin
          report_group("branches", exp_count - X0_END);
          done = 1'b1;
        end
      end
    end
  end

endmodule

/* rv_core.f */
+incdir+include
hw/rv_pipe_pkg.sv
hw/rv_isa_pkg.sv
hw/rv_pipe_if.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_core_top.sv
dv/rv_core_sva.sv
dv/rv_core_tb.sv

/* dv/rv_core_golden.txt */
// counts: program words, expected retirements; then the program, four words per line
// then expected retirements, two per line, each as: pc rd data
00000028 00000020
800000B7 FFB00113 00700193 00310233
402182B3 00317333 003163B3 00314433
003194B3 0030D533 4030D5B3 00312633
003136B3 0F017713 FF01E793 FFF14813
00419893 0040D913 4040D993 FFC12A13
FFF1BA93 00518013 00300B33 00318663
00100F93 00100F93 00319663 00314663
00100F93 00100F93 00316663 00315663
00317663 00100F93 00100F93 00C10B93
003B8663 00100F93 00100F93 00000063
00000000 00000001 80000000  00000004 00000002 FFFFFFFB
00000008 00000003 00000007  0000000C 00000004 00000002
00000010 00000005 0000000C  00000014 00000006 00000003
00000018 00000007 FFFFFFFF  0000001C 00000008 FFFFFFFC
00000020 00000009 00000380  00000024 0000000A 01000000
00000028 0000000B FF000000  0000002C 0000000C 00000001
00000030 0000000D 00000000  00000034 0000000E 000000F0
00000038 0000000F FFFFFFF7  0000003C 00000010 00000004
00000040 00000011 00000070  00000044 00000012 08000000
00000048 00000013 F8000000  0000004C 00000014 00000001
00000050 00000015 00000001  00000054 00000000 00000000
00000058 00000016 00000007  0000005C 00000000 00000000
00000068 00000000 00000000  0000006C 00000000 00000000
00000078 00000000 00000000  0000007C 00000000 00000000
00000080 00000000 00000000  0000008C 00000017 00000007
00000090 00000000 00000000  0000009C 00000000 00000000
